// ==== source/axi_pkg.sv ====
package axi_pkg;

  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  // beats minus one.
  typedef logic [LEN_W-1:0]   len_t;

  // bytes per beat, log2.
  typedef logic [SIZE_W-1:0]  size_t;

  typedef logic [BURST_W-1:0] burst_t;  // fixed, incr, wrap.

  typedef logic [RESP_W-1:0]  resp_t;   // okay, exokay, slverr, decerr.

endpackage

// ==== source/arbt_pkg.sv ====
package arbt_pkg;

  localparam int N_PORT = 4;  // masters merged.
  localparam int PORT_W = 2;
  localparam int ID_W   = 4;
  localparam int TAG_W  = ID_W - PORT_W;

  // one bit per master.
  typedef logic [N_PORT-1:0] port_vec_t;

  // ####################################################################
  // id as seen on the bus, or split for routing
  // ####################################################################

  // port field replaces the master's upper id bits on the slave side.
  typedef union packed {
    logic [ID_W-1:0] raw;
    struct packed {
      logic [PORT_W-1:0] port;  // source master index.
      logic [TAG_W-1:0]  tag;   // master's own id bits.
    } f;
  } axi_id_u;

endpackage

// ==== source/addr_arbiter.sv ====
`timescale 1ns/1ps

module addr_arbiter #(
  parameter int ADDR_W = 32
) (
  input  arbt_pkg::port_vec_t                            i_valid,
  input  logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]     i_id,
  input  logic [arbt_pkg::N_PORT*ADDR_W-1:0]             i_addr,
  input  logic [arbt_pkg::N_PORT*axi_pkg::LEN_W-1:0]     i_len,
  input  logic [arbt_pkg::N_PORT*axi_pkg::SIZE_W-1:0]    i_size,
  input  logic [arbt_pkg::N_PORT*axi_pkg::BURST_W-1:0]   i_burst,
  input  logic                                           i_ready,
  output arbt_pkg::port_vec_t                            o_ready,
  output arbt_pkg::port_vec_t                            o_grant,
  output logic                                           o_valid,
  output arbt_pkg::axi_id_u                              o_id,
  output logic [ADDR_W-1:0]                              o_addr,
  output axi_pkg::len_t                                  o_len,
  output axi_pkg::size_t                                 o_size,
  output axi_pkg::burst_t                                o_burst
);

  logic [arbt_pkg::PORT_W-1:0] win_idx;
  arbt_pkg::axi_id_u           win_id;

  // ####################################################################
  // fixed priority, port 0 highest
  // ####################################################################

  // isolate the lowest set request bit.
  assign o_grant = i_valid & (~i_valid + 1'b1);
  assign o_valid = |i_valid;

  always_comb begin
    win_idx = '0;
    for (int p = arbt_pkg::N_PORT - 1; p >= 0; p--) begin
      if (i_valid[p]) begin
        win_idx = p[arbt_pkg::PORT_W-1:0];  // last hit is the lowest.
      end
    end
  end

  // slave ready only reaches the winner.
  assign o_ready = o_grant & {arbt_pkg::N_PORT{i_ready}};

  // ####################################################################
  // field mux and id remap
  // ####################################################################

  assign win_id.raw = i_id[win_idx*arbt_pkg::ID_W +: arbt_pkg::ID_W];

  always_comb begin
    o_id        = win_id;
    o_id.f.port = win_idx;  // upper bits now name the master.
  end

  assign o_addr  = i_addr[win_idx*ADDR_W +: ADDR_W];
  assign o_len   = i_len[win_idx*axi_pkg::LEN_W +: axi_pkg::LEN_W];
  assign o_size  = i_size[win_idx*axi_pkg::SIZE_W +: axi_pkg::SIZE_W];
  assign o_burst = i_burst[win_idx*axi_pkg::BURST_W +: axi_pkg::BURST_W];

endmodule

// ==== source/w_order.sv ====
`timescale 1ns/1ps

module w_order #(
  parameter int  FIFO_DEPTH = 2,
  parameter int  DATA_W     = 32,
  localparam int STRB_W     = DATA_W / 8
) (
  input  logic                                         i_clk,
  input  logic                                         i_rst_n,
  input  logic                                         i_aw_valid,
  input  arbt_pkg::port_vec_t                          i_aw_grant,
  input  axi_pkg::len_t                                i_aw_len,
  input  logic                                         i_axi_awready,
  output logic                                         o_aw_ready,
  output logic                                         o_axi_awvalid,
  input  arbt_pkg::port_vec_t                          i_wvalid,
  input  logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]   i_wid,
  input  logic [arbt_pkg::N_PORT*DATA_W-1:0]           i_wdata,
  input  logic [arbt_pkg::N_PORT*STRB_W-1:0]           i_wstrb,
  input  arbt_pkg::port_vec_t                          i_wlast,
  output arbt_pkg::port_vec_t                          o_wready,
  output logic                                         o_axi_wvalid,
  output arbt_pkg::axi_id_u                            o_axi_wid,
  output logic [DATA_W-1:0]                            o_axi_wdata,
  output logic [STRB_W-1:0]                            o_axi_wstrb,
  output logic                                         o_axi_wlast,
  input  logic                                         i_axi_wready
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  arbt_pkg::port_vec_t         fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            count;
  logic                        fifo_empty;
  logic                        fifo_full;
  logic                        fifo_wen;
  logic                        fifo_ren;
  logic                        aw_fire;
  logic                        w_fire;
  logic                        bypass_cand;
  logic                        bypass;
  arbt_pkg::port_vec_t         w_sel;
  logic [arbt_pkg::PORT_W-1:0] w_idx;
  arbt_pkg::axi_id_u           w_id_in;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ####################################################################
  // aw acceptance, held back while the order fifo is full
  // ####################################################################

  assign fifo_empty    = (count == '0);
  assign fifo_full     = (count == CNT_W'(FIFO_DEPTH));
  assign o_axi_awvalid = i_aw_valid & ~fifo_full;
  assign o_aw_ready    = i_axi_awready & ~fifo_full;
  assign aw_fire       = o_axi_awvalid & i_axi_awready;

  // single beat, empty fifo, owner already presenting its beat.
  assign bypass_cand = fifo_empty & aw_fire & (i_aw_len == '0)
                     & (|(i_wvalid & i_aw_grant));
  assign bypass      = bypass_cand & i_axi_wready;

  // no owner means no beat goes out.
  assign w_sel = bypass_cand ? i_aw_grant :
                 fifo_empty  ? '0         : fifo_mem[rd_ptr];

  assign w_fire   = o_axi_wvalid & i_axi_wready;
  assign fifo_wen = aw_fire & ~bypass;
  assign fifo_ren = w_fire & o_axi_wlast & ~bypass;  // pop on last beat.

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (fifo_wen) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (fifo_ren) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(fifo_wen) - CNT_W'(fifo_ren);
    end
  end

  always_ff @(posedge i_clk) begin
    if (fifo_wen) begin
      fifo_mem[wr_ptr] <= i_aw_grant;
    end
  end

  // ####################################################################
  // w beat mux
  // ####################################################################

  always_comb begin
    w_idx = '0;
    for (int p = 0; p < arbt_pkg::N_PORT; p++) begin
      if (w_sel[p]) begin
        w_idx = p[arbt_pkg::PORT_W-1:0];
      end
    end
  end

  assign o_axi_wvalid = |(i_wvalid & w_sel);
  assign o_wready     = w_sel & {arbt_pkg::N_PORT{i_axi_wready}};
  assign w_id_in.raw  = i_wid[w_idx*arbt_pkg::ID_W +: arbt_pkg::ID_W];

  always_comb begin
    o_axi_wid        = w_id_in;
    o_axi_wid.f.port = w_idx;
  end

  assign o_axi_wdata = i_wdata[w_idx*DATA_W +: DATA_W];
  assign o_axi_wstrb = i_wstrb[w_idx*STRB_W +: STRB_W];
  assign o_axi_wlast = i_wlast[w_idx];

endmodule

// ==== source/rsp_route.sv ====
`timescale 1ns/1ps

module rsp_route #(
  parameter int DATA_W = 32
) (
  input  logic                                         i_axi_rvalid,
  input  arbt_pkg::axi_id_u                            i_axi_rid,
  input  logic [DATA_W-1:0]                            i_axi_rdata,
  input  axi_pkg::resp_t                               i_axi_rresp,
  input  logic                                         i_axi_rlast,
  input  logic                                         i_axi_bvalid,
  input  arbt_pkg::axi_id_u                            i_axi_bid,
  input  axi_pkg::resp_t                               i_axi_bresp,
  output logic                                         o_axi_rready,
  output logic                                         o_axi_bready,
  input  arbt_pkg::port_vec_t                          i_rready,
  input  arbt_pkg::port_vec_t                          i_bready,
  output arbt_pkg::port_vec_t                          o_rvalid,
  output arbt_pkg::port_vec_t                          o_bvalid,
  output logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]   o_rid,
  output logic [arbt_pkg::N_PORT*DATA_W-1:0]           o_rdata,
  output logic [arbt_pkg::N_PORT*axi_pkg::RESP_W-1:0]  o_rresp,
  output arbt_pkg::port_vec_t                          o_rlast,
  output logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]   o_bid,
  output logic [arbt_pkg::N_PORT*axi_pkg::RESP_W-1:0]  o_bresp
);

  // one-hot of the master named by the id.
  function automatic arbt_pkg::port_vec_t port_dec(input arbt_pkg::axi_id_u id);
    arbt_pkg::port_vec_t vec;
    vec            = '0;
    vec[id.f.port] = 1'b1;
    return vec;
  endfunction

  assign o_rvalid     = port_dec(i_axi_rid) & {arbt_pkg::N_PORT{i_axi_rvalid}};
  assign o_bvalid     = port_dec(i_axi_bid) & {arbt_pkg::N_PORT{i_axi_bvalid}};
  assign o_axi_rready = i_rready[i_axi_rid.f.port];  // stall only the owner.
  assign o_axi_bready = i_bready[i_axi_bid.f.port];

  // payload goes to every master, valid picks the one.
  assign o_rid   = {arbt_pkg::N_PORT{i_axi_rid.raw}};
  assign o_rdata = {arbt_pkg::N_PORT{i_axi_rdata}};
  assign o_rresp = {arbt_pkg::N_PORT{i_axi_rresp}};
  assign o_rlast = {arbt_pkg::N_PORT{i_axi_rlast}};
  assign o_bid   = {arbt_pkg::N_PORT{i_axi_bid.raw}};
  assign o_bresp = {arbt_pkg::N_PORT{i_axi_bresp}};

endmodule

// ==== source/axi_arbt_top.sv ====
`timescale 1ns/1ps

module axi_arbt_top #(
  parameter int  ADDR_W     = 32,
  parameter int  DATA_W     = 32,
  parameter int  FIFO_DEPTH = 2,
  localparam int STRB_W     = DATA_W / 8
) (
  input  logic                                           i_clk,
  input  logic                                           i_rst_n,
  // masters, read address.
  input  arbt_pkg::port_vec_t                            i_m_arvalid,
  input  logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]     i_m_arid,
  input  logic [arbt_pkg::N_PORT*ADDR_W-1:0]             i_m_araddr,
  input  logic [arbt_pkg::N_PORT*axi_pkg::LEN_W-1:0]     i_m_arlen,
  input  logic [arbt_pkg::N_PORT*axi_pkg::SIZE_W-1:0]    i_m_arsize,
  input  logic [arbt_pkg::N_PORT*axi_pkg::BURST_W-1:0]   i_m_arburst,
  output arbt_pkg::port_vec_t                            o_m_arready,
  // masters, write address.
  input  arbt_pkg::port_vec_t                            i_m_awvalid,
  input  logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]     i_m_awid,
  input  logic [arbt_pkg::N_PORT*ADDR_W-1:0]             i_m_awaddr,
  input  logic [arbt_pkg::N_PORT*axi_pkg::LEN_W-1:0]     i_m_awlen,
  input  logic [arbt_pkg::N_PORT*axi_pkg::SIZE_W-1:0]    i_m_awsize,
  input  logic [arbt_pkg::N_PORT*axi_pkg::BURST_W-1:0]   i_m_awburst,
  output arbt_pkg::port_vec_t                            o_m_awready,
  // masters, write data.
  input  arbt_pkg::port_vec_t                            i_m_wvalid,
  input  logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]     i_m_wid,
  input  logic [arbt_pkg::N_PORT*DATA_W-1:0]             i_m_wdata,
  input  logic [arbt_pkg::N_PORT*STRB_W-1:0]             i_m_wstrb,
  input  arbt_pkg::port_vec_t                            i_m_wlast,
  output arbt_pkg::port_vec_t                            o_m_wready,
  // masters, responses.
  output arbt_pkg::port_vec_t                            o_m_rvalid,
  output logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]     o_m_rid,
  output logic [arbt_pkg::N_PORT*DATA_W-1:0]             o_m_rdata,
  output logic [arbt_pkg::N_PORT*axi_pkg::RESP_W-1:0]    o_m_rresp,
  output arbt_pkg::port_vec_t                            o_m_rlast,
  input  arbt_pkg::port_vec_t                            i_m_rready,
  output arbt_pkg::port_vec_t                            o_m_bvalid,
  output logic [arbt_pkg::N_PORT*arbt_pkg::ID_W-1:0]     o_m_bid,
  output logic [arbt_pkg::N_PORT*axi_pkg::RESP_W-1:0]    o_m_bresp,
  input  arbt_pkg::port_vec_t                            i_m_bready,
  // slave port.
  output logic                                           o_axi_arvalid,
  output logic [arbt_pkg::ID_W-1:0]                      o_axi_arid,
  output logic [ADDR_W-1:0]                              o_axi_araddr,
  output axi_pkg::len_t                                  o_axi_arlen,
  output axi_pkg::size_t                                 o_axi_arsize,
  output axi_pkg::burst_t                                o_axi_arburst,
  input  logic                                           i_axi_arready,
  output logic                                           o_axi_awvalid,
  output logic [arbt_pkg::ID_W-1:0]                      o_axi_awid,
  output logic [ADDR_W-1:0]                              o_axi_awaddr,
  output axi_pkg::len_t                                  o_axi_awlen,
  output axi_pkg::size_t                                 o_axi_awsize,
  output axi_pkg::burst_t                                o_axi_awburst,
  input  logic                                           i_axi_awready,
  output logic                                           o_axi_wvalid,
  output logic [arbt_pkg::ID_W-1:0]                      o_axi_wid,
  output logic [DATA_W-1:0]                              o_axi_wdata,
  output logic [STRB_W-1:0]                              o_axi_wstrb,
  output logic                                           o_axi_wlast,
  input  logic                                           i_axi_wready,
  input  logic                                           i_axi_rvalid,
  input  logic [arbt_pkg::ID_W-1:0]                      i_axi_rid,
  input  logic [DATA_W-1:0]                              i_axi_rdata,
  input  axi_pkg::resp_t                                 i_axi_rresp,
  input  logic                                           i_axi_rlast,
  output logic                                           o_axi_rready,
  input  logic                                           i_axi_bvalid,
  input  logic [arbt_pkg::ID_W-1:0]                      i_axi_bid,
  input  axi_pkg::resp_t                                 i_axi_bresp,
  output logic                                           o_axi_bready
);

  logic                aw_valid;  // arbiter request, before fifo room.
  logic                aw_ready;
  arbt_pkg::port_vec_t aw_grant;

  // ####################################################################
  // address stage
  // ####################################################################

  addr_arbiter #(.ADDR_W(ADDR_W)) u_ar_arbiter (
    .i_valid (i_m_arvalid),
    .i_id    (i_m_arid),
    .i_addr  (i_m_araddr),
    .i_len   (i_m_arlen),
    .i_size  (i_m_arsize),
    .i_burst (i_m_arburst),
    .i_ready (i_axi_arready),
    .o_ready (o_m_arready),
    .o_grant (),
    .o_valid (o_axi_arvalid),
    .o_id    (o_axi_arid),
    .o_addr  (o_axi_araddr),
    .o_len   (o_axi_arlen),
    .o_size  (o_axi_arsize),
    .o_burst (o_axi_arburst)
  );

  addr_arbiter #(.ADDR_W(ADDR_W)) u_aw_arbiter (
    .i_valid (i_m_awvalid),
    .i_id    (i_m_awid),
    .i_addr  (i_m_awaddr),
    .i_len   (i_m_awlen),
    .i_size  (i_m_awsize),
    .i_burst (i_m_awburst),
    .i_ready (aw_ready),
    .o_ready (o_m_awready),
    .o_grant (aw_grant),
    .o_valid (aw_valid),
    .o_id    (o_axi_awid),
    .o_addr  (o_axi_awaddr),
    .o_len   (o_axi_awlen),
    .o_size  (o_axi_awsize),
    .o_burst (o_axi_awburst)
  );

  // ####################################################################
  // write order stage and response routing
  // ####################################################################

  w_order #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .DATA_W     (DATA_W)
  ) u_w_order (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_aw_valid    (aw_valid),
    .i_aw_grant    (aw_grant),
    .i_aw_len      (o_axi_awlen),
    .i_axi_awready (i_axi_awready),
    .o_aw_ready    (aw_ready),
    .o_axi_awvalid (o_axi_awvalid),
    .i_wvalid      (i_m_wvalid),
    .i_wid         (i_m_wid),
    .i_wdata       (i_m_wdata),
    .i_wstrb       (i_m_wstrb),
    .i_wlast       (i_m_wlast),
    .o_wready      (o_m_wready),
    .o_axi_wvalid  (o_axi_wvalid),
    .o_axi_wid     (o_axi_wid),
    .o_axi_wdata   (o_axi_wdata),
    .o_axi_wstrb   (o_axi_wstrb),
    .o_axi_wlast   (o_axi_wlast),
    .i_axi_wready  (i_axi_wready)
  );

  rsp_route #(.DATA_W(DATA_W)) u_rsp_route (
    .i_axi_rvalid (i_axi_rvalid),
    .i_axi_rid    (i_axi_rid),
    .i_axi_rdata  (i_axi_rdata),
    .i_axi_rresp  (i_axi_rresp),
    .i_axi_rlast  (i_axi_rlast),
    .i_axi_bvalid (i_axi_bvalid),
    .i_axi_bid    (i_axi_bid),
    .i_axi_bresp  (i_axi_bresp),
    .o_axi_rready (o_axi_rready),
    .o_axi_bready (o_axi_bready),
    .i_rready     (i_m_rready),
    .i_bready     (i_m_bready),
    .o_rvalid     (o_m_rvalid),
    .o_bvalid     (o_m_bvalid),
    .o_rid        (o_m_rid),
    .o_rdata      (o_m_rdata),
    .o_rresp      (o_m_rresp),
    .o_rlast      (o_m_rlast),
    .o_bid        (o_m_bid),
    .o_bresp      (o_m_bresp)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD  = 100,
  parameter int RST_CYC = 2
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk   = 1'b0;
    o_rst_n = 1'b0;
    repeat (RST_CYC) @(posedge o_clk);
    o_rst_n <= 1'b1;  // released on an edge.
  end

  always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// ==== tb/axi_arbt_sva.sv ====
`timescale 1ns/1ps

module axi_arbt_sva (
  input logic        i_clk,
  input logic        i_rst_n,
  input logic        o_axi_arvalid,
  input logic [3:0]  o_axi_arid,
  input logic [31:0] o_axi_araddr,
  input logic        o_axi_awvalid,
  input logic [3:0]  o_axi_awid,
  input logic [31:0] o_axi_awaddr,
  input logic        i_axi_awready,
  input logic        o_axi_wvalid,
  input logic [3:0]  o_axi_wid,
  input logic [31:0] o_axi_wdata,
  input logic [3:0]  o_m_arready,
  input logic [3:0]  o_m_awready,
  input logic [3:0]  o_m_wready
);

  logic aw_seen;  // any aw accepted since reset.
  int   fail_count = 0;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      aw_seen <= 1'b0;
    end else if (o_axi_awvalid && i_axi_awready) begin
      aw_seen <= 1'b1;
    end
  end

  a_ar_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_axi_arvalid |-> !$isunknown({o_axi_arid, o_axi_araddr}))
    else begin
      fail_count++;
      $error("ar fields unknown while valid");
    end
  a_aw_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_axi_awvalid |-> !$isunknown({o_axi_awid, o_axi_awaddr}))
    else begin
      fail_count++;
      $error("aw fields unknown while valid");
    end
  a_w_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_axi_wvalid |-> !$isunknown({o_axi_wid, o_axi_wdata}))
    else begin
      fail_count++;
      $error("w fields unknown while valid");
    end
  a_ready_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(o_m_arready) && $onehot0(o_m_awready) && $onehot0(o_m_wready))
    else begin
      fail_count++;
      $error("more than one master ready on a channel");
    end
  // bypass may send the first beat with the first aw.
  a_w_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!aw_seen && !(o_axi_awvalid && i_axi_awready)) |-> !o_axi_wvalid)
    else begin
      fail_count++;
      $error("w valid before any aw accepted");
    end

endmodule

bind axi_arbt_top axi_arbt_sva u_sva (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .o_axi_arvalid (o_axi_arvalid),
  .o_axi_arid    (o_axi_arid),
  .o_axi_araddr  (o_axi_araddr),
  .o_axi_awvalid (o_axi_awvalid),
  .o_axi_awid    (o_axi_awid),
  .o_axi_awaddr  (o_axi_awaddr),
  .i_axi_awready (i_axi_awready),
  .o_axi_wvalid  (o_axi_wvalid),
  .o_axi_wid     (o_axi_wid),
  .o_axi_wdata   (o_axi_wdata),
  .o_m_arready   (o_m_arready),
  .o_m_awready   (o_m_awready),
  .o_m_wready    (o_m_wready)
);

// ==== tb/axi_arbt_tb.sv ====
`timescale 1ns/1ps

module axi_arbt_tb;

  localparam int DEPTH   = 2;
  localparam int N_MIX   = 1500;
  localparam int N_FULL  = 300;
  localparam int N_DRAIN = 300;
  localparam int N_BYP   = 400;
  localparam int TIMEOUT = N_MIX + N_FULL + N_DRAIN + N_BYP + 1500;  // 4000 with margin.

  logic clk;
  logic rst_n;
  logic [31:0] lcg_state = 32'heecdf512;
  int errors = 0;
  int sva_fails = 0;
  int cycles = 0;
  int full_seen = 0;
  int bypass_seen = 0;
  string test_name = "reset";
  int owners [$];  // accepted aw owners, oldest first.

  logic [3:0] m_arvalid, m_awvalid, m_wvalid, m_wlast, m_rready, m_bready;
  logic [15:0] m_arid, m_awid, m_wid, m_wstrb;
  logic [127:0] m_araddr, m_awaddr, m_wdata;
  logic [31:0] m_arlen, m_awlen;
  logic [11:0] m_arsize, m_awsize;
  logic [7:0] m_arburst, m_awburst;
  logic arready, awready, wready, rvalid, rlast, bvalid;
  logic [3:0] rid, bid;
  logic [31:0] rdata;
  logic [1:0] rresp, bresp;

  wire [3:0] o_m_arready, o_m_awready, o_m_wready, o_m_rvalid, o_m_rlast, o_m_bvalid;
  wire [15:0] o_m_rid, o_m_bid;
  wire [127:0] o_m_rdata;
  wire [7:0] o_m_rresp, o_m_bresp;
  wire o_arvalid, o_awvalid, o_wvalid, o_wlast, o_rready, o_bready;
  wire [3:0] o_arid, o_awid, o_wid, o_wstrb;
  wire [31:0] o_araddr, o_awaddr, o_wdata;
  wire [7:0] o_arlen, o_awlen;
  wire [2:0] o_arsize, o_awsize;
  wire [1:0] o_arburst, o_awburst;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

  axi_arbt_top #(.FIFO_DEPTH(DEPTH)) dut (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_m_arvalid(m_arvalid), .i_m_arid(m_arid), .i_m_araddr(m_araddr),
    .i_m_arlen(m_arlen), .i_m_arsize(m_arsize), .i_m_arburst(m_arburst),
    .o_m_arready(o_m_arready),
    .i_m_awvalid(m_awvalid), .i_m_awid(m_awid), .i_m_awaddr(m_awaddr),
    .i_m_awlen(m_awlen), .i_m_awsize(m_awsize), .i_m_awburst(m_awburst),
    .o_m_awready(o_m_awready),
    .i_m_wvalid(m_wvalid), .i_m_wid(m_wid), .i_m_wdata(m_wdata),
    .i_m_wstrb(m_wstrb), .i_m_wlast(m_wlast), .o_m_wready(o_m_wready),
    .o_m_rvalid(o_m_rvalid), .o_m_rid(o_m_rid), .o_m_rdata(o_m_rdata),
    .o_m_rresp(o_m_rresp), .o_m_rlast(o_m_rlast), .i_m_rready(m_rready),
    .o_m_bvalid(o_m_bvalid), .o_m_bid(o_m_bid), .o_m_bresp(o_m_bresp),
    .i_m_bready(m_bready),
    .o_axi_arvalid(o_arvalid), .o_axi_arid(o_arid), .o_axi_araddr(o_araddr),
    .o_axi_arlen(o_arlen), .o_axi_arsize(o_arsize), .o_axi_arburst(o_arburst),
    .i_axi_arready(arready),
    .o_axi_awvalid(o_awvalid), .o_axi_awid(o_awid), .o_axi_awaddr(o_awaddr),
    .o_axi_awlen(o_awlen), .o_axi_awsize(o_awsize), .o_axi_awburst(o_awburst),
    .i_axi_awready(awready),
    .o_axi_wvalid(o_wvalid), .o_axi_wid(o_wid), .o_axi_wdata(o_wdata),
    .o_axi_wstrb(o_wstrb), .o_axi_wlast(o_wlast), .i_axi_wready(wready),
    .i_axi_rvalid(rvalid), .i_axi_rid(rid), .i_axi_rdata(rdata),
    .i_axi_rresp(rresp), .i_axi_rlast(rlast), .o_axi_rready(o_rready),
    .i_axi_bvalid(bvalid), .i_axi_bid(bid), .i_axi_bresp(bresp),
    .o_axi_bready(o_bready)
  );

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);  // fold high bits into the weak low ones.
  endfunction

  // ####################################################################
  // reference model
  // ####################################################################

  // lowest valid index wins, -1 when nobody requests.
  function automatic int ref_grant(input logic [3:0] vec);
    int idx;
    idx = -1;
    for (int p = 3; p >= 0; p--) begin
      if (vec[p]) idx = p;
    end
    return idx;
  endfunction

  function automatic logic [3:0] remap_id(input int idx, input logic [15:0] ids);
    logic [3:0] raw;
    raw = ids[idx*4 +: 4];
    return {idx[1:0], raw[1:0]};  // port over tag.
  endfunction

  task automatic check_val(input string what, input logic [127:0] exp,
                           input logic [127:0] act);
    if (exp !== act) begin
      errors++;
      $display("error %s/%s: expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  // ####################################################################
  // stimulus
  // ####################################################################

  task automatic drive_cycle(input int phase);
    logic [31:0] r;
    r = lcg_next();
    for (int p = 0; p < 4; p++) begin
      m_araddr[p*32 +: 32] <= lcg_next();
      m_awaddr[p*32 +: 32] <= lcg_next();
      m_wdata[p*32 +: 32]  <= lcg_next();
    end
    m_arvalid <= r[3:0];
    m_arid    <= lcg_next();
    m_arlen   <= lcg_next();
    m_arsize  <= lcg_next();
    m_arburst <= lcg_next();
    m_awid    <= lcg_next();
    m_awsize  <= lcg_next();
    m_awburst <= lcg_next();
    m_wid     <= lcg_next();
    m_wstrb   <= lcg_next();
    arready   <= r[4];
    {rvalid, rlast, bvalid, rresp, bresp} <= r[11:5];
    {rid, bid} <= r[19:12];
    rdata     <= lcg_next();
    {m_rready, m_bready} <= r[27:20];
    case (phase)
      0: begin
        m_awvalid <= r[31:28];
        m_awlen   <= lcg_next() & 32'h03030303;  // short bursts.
        m_wvalid  <= lcg_next();
        m_wlast   <= lcg_next();
        {awready, wready} <= lcg_next();
      end
      1: begin
        m_awvalid <= r[31:28] | 4'b0001;
        m_awlen   <= lcg_next();
        m_wvalid  <= '0;
        awready   <= 1'b1;
        wready    <= 1'b1;
      end
      2: begin
        m_awvalid <= '0;
        m_wvalid  <= '1;
        m_wlast   <= lcg_next();
        wready    <= 1'b1;
      end
      default: begin
        m_awvalid <= r[31:28];
        m_awlen   <= '0;
        m_wvalid  <= '1;
        m_wlast   <= '1;
        awready   <= 1'b1;
        wready    <= 1'b1;
      end
    endcase
  endtask

  task automatic run_phase(input string name, input int phase, input int n);
    test_name = name;
    repeat (n) begin
      @(posedge clk);
      drive_cycle(phase);
    end
  endtask

  initial begin
    {m_arvalid, m_awvalid, m_wvalid, m_wlast, m_rready, m_bready} = '0;
    {m_arid, m_awid, m_wid, m_wstrb, m_araddr, m_awaddr, m_wdata} = '0;
    {m_arlen, m_awlen, m_arsize, m_awsize, m_arburst, m_awburst} = '0;
    {arready, awready, wready, rvalid, rlast, bvalid, rid, bid} = '0;
    {rdata, rresp, bresp} = '0;
    @(posedge rst_n);
    run_phase("random_mix", 0, N_MIX);
    run_phase("fifo_full", 1, N_FULL);
    run_phase("drain", 2, N_DRAIN);
    run_phase("bypass", 3, N_BYP);
    @(posedge clk);
    @(negedge clk);
    if (full_seen == 0) begin
      errors++;
      $display("aw was never held back by a full order fifo");
    end
    if (bypass_seen == 0) begin
      errors++;
      $display("no single-beat write took the bypass path");
    end
    sva_fails = dut.u_sva.fail_count;
    $display("errors: %0d, assertion failures: %0d, cycles: %0d",
             errors, sva_fails, cycles);
    if (errors == 0 && sva_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT);
      $display("sim failed");
      $finish;
    end
  end

  // ####################################################################
  // compare, outputs settled mid-cycle
  // ####################################################################

  always @(negedge clk) begin
    int ar_idx, aw_idx, sel, rp, bp;
    bit full, aw_fire, byp_cand, byp, w_fire, exp_wvalid;
    if (rst_n) begin
      ar_idx = ref_grant(m_arvalid);
      check_val("arvalid", ar_idx >= 0, o_arvalid);
      check_val("arready", (ar_idx >= 0 && arready) ? 4'(1 << ar_idx) : 4'h0, o_m_arready);
      if (ar_idx >= 0) begin
        check_val("arid", remap_id(ar_idx, m_arid), o_arid);
        check_val("araddr", m_araddr[ar_idx*32 +: 32], o_araddr);
        check_val("arlen", m_arlen[ar_idx*8 +: 8], o_arlen);
        check_val("arsize", m_arsize[ar_idx*3 +: 3], o_arsize);
        check_val("arburst", m_arburst[ar_idx*2 +: 2], o_arburst);
      end

      aw_idx  = ref_grant(m_awvalid);
      full    = (owners.size() == DEPTH);
      aw_fire = (aw_idx >= 0) && !full && awready;
      check_val("awvalid", (aw_idx >= 0) && !full, o_awvalid);
      check_val("awready", aw_fire ? 4'(1 << aw_idx) : 4'h0, o_m_awready);
      if (aw_idx >= 0) begin
        check_val("awid", remap_id(aw_idx, m_awid), o_awid);
        check_val("awaddr", m_awaddr[aw_idx*32 +: 32], o_awaddr);
        check_val("awlen", m_awlen[aw_idx*8 +: 8], o_awlen);
        check_val("awsize", m_awsize[aw_idx*3 +: 3], o_awsize);
        check_val("awburst", m_awburst[aw_idx*2 +: 2], o_awburst);
      end
      if (full && aw_idx >= 0) full_seen++;

      // w owner from bypass or queue head.
      byp_cand = (owners.size() == 0) && aw_fire && (m_awlen[aw_idx*8 +: 8] == 0)
               && m_wvalid[aw_idx];
      sel = byp_cand ? aw_idx : (owners.size() > 0 ? owners[0] : -1);
      exp_wvalid = (sel >= 0) && m_wvalid[sel];
      check_val("wvalid", exp_wvalid, o_wvalid);
      check_val("wready", (sel >= 0 && wready) ? 4'(1 << sel) : 4'h0, o_m_wready);
      if (exp_wvalid) begin
        check_val("wid", remap_id(sel, m_wid), o_wid);
        check_val("wdata", m_wdata[sel*32 +: 32], o_wdata);
        check_val("wstrb", m_wstrb[sel*4 +: 4], o_wstrb);
        check_val("wlast", m_wlast[sel], o_wlast);
      end
      byp    = byp_cand && wready;
      w_fire = exp_wvalid && wready;
      if (byp) bypass_seen++;
      if (w_fire && m_wlast[sel] && !byp) void'(owners.pop_front());
      if (aw_fire && !byp) owners.push_back(aw_idx);

      rp = rid[3:2];
      bp = bid[3:2];
      check_val("rvalid", rvalid ? 4'(1 << rp) : 4'h0, o_m_rvalid);
      check_val("bvalid", bvalid ? 4'(1 << bp) : 4'h0, o_m_bvalid);
      check_val("rready", m_rready[rp], o_rready);
      check_val("bready", m_bready[bp], o_bready);
      check_val("rid", {4{rid}}, o_m_rid);
      check_val("rdata", {4{rdata}}, o_m_rdata);
      check_val("rresp", {4{rresp}}, o_m_rresp);
      check_val("rlast", {4{rlast}}, o_m_rlast);
      check_val("bid", {4{bid}}, o_m_bid);
      check_val("bresp", {4{bresp}}, o_m_bresp);
    end
  end

endmodule

// ==== axi_arbt_top.f ====
source/axi_pkg.sv
source/arbt_pkg.sv
source/addr_arbiter.sv
source/w_order.sv
source/rsp_route.sv
source/axi_arbt_top.sv
tb/tb_clk_gen.sv
tb/axi_arbt_sva.sv
tb/axi_arbt_tb.sv
